/* irq_ctrl.f */
+incdir+design
+incdir+bench
design/irq_pkg.sv
design/irq_mode_loader.sv
design/irq_priority_slot.sv
design/irq_arbiter.sv
design/irq_sequencer.sv
design/irq_ctrl.sv
bench/irq_ctrl_tb.sv

/* bench/irq_ctrl_tb_tasks.svh */
`ifndef IRQ_CTRL_TB_TASKS_SVH
`define IRQ_CTRL_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Random numbers
//////////////////////////////////////////////////////////////////////
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// Random non-empty request vector
function automatic logic [7:0] rand_request();
    logic [31:0] r;
    logic [7:0]  v;
    r = next_rand();
    v = r[7:0];
    if (v == 8'h00) begin
        v = 8'h01 << r[10:8];                       // Fall back to a single source
    end
    return v;
endfunction

// Shuffled table holding every source exactly once
task automatic build_table(output logic [23:0] t);
    logic [2:0]  perm [8];
    logic [2:0]  tmp;
    logic [31:0] r;
    int          j;
    for (int i = 0; i < 8; i++) begin
        perm[i] = i[2:0];
    end
    for (int i = 7; i > 0; i--) begin              // Swap shuffle from the top down
        r = next_rand();
        j = r % (i + 1);
        tmp     = perm[i];
        perm[i] = perm[j];
        perm[j] = tmp;
    end
    for (int i = 0; i < 8; i++) begin
        t[3*i +: 3] = perm[i];                      // Rank 0 in the low bits
    end
endtask

//////////////////////////////////////////////////////////////////////
// Reference model and checking
//////////////////////////////////////////////////////////////////////

// Grant word {code, id} the processor should see
function automatic logic [7:0] expected_grant(input irq_mode_t mode, input logic [7:0] rq,
                                              input logic [23:0] t, input int poll_idx);
    int src;
    for (int i = 0; i < 8; i++) begin
        if (mode == MODE_POLL) begin
            src = (poll_idx + i) % 8;               // Cyclic scan from the index
        end else begin
            src = t[3*i +: 3];                      // Best rank first
        end
        if (rq[src]) begin
            return (mode == MODE_POLL) ? {`IRQ_POLL_GRANT, src[2:0]}
                                       : {`IRQ_PRIO_GRANT, src[2:0]};
        end
    end
    return 8'h00;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks_run++;
    if (got !== exp) begin
        errors++;
        $display("Fail %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
    end
endtask

task automatic report_test(input int num, input string name);
    $display("test %0d %s: done, %0d errors so far", num, name, errors);
endtask

//////////////////////////////////////////////////////////////////////
// Stimulus driven on the falling edge
//////////////////////////////////////////////////////////////////////
task automatic apply_reset();
    rst_in       = 1'b1;
    intr_mode    = MODE_NONE;
    intr_rq      = '0;
    intr_in      = 1'b1;                            // Ack idles high
    intr_ack_bus = '0;
    last_id      = '0;
    repeat (4) @(negedge clk_in);
    rst_in = 1'b0;
endtask

task automatic set_mode(input irq_mode_t m);
    cur_mode  = m;
    intr_mode = m;
endtask

// intr_out must stay low for n cycles
task automatic quiet_cycles(input int n);
    repeat (n) begin
        @(negedge clk_in);
        check("intr_out", intr_out, 1'b0);
    end
endtask

// One sampled-low cycle on intr_in
task automatic pulse_ack();
    intr_in = 1'b0;
    @(negedge clk_in);
    intr_in = 1'b1;
endtask

task automatic wait_intr_out(input int max_cycles, output bit seen);
    int n;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < max_cycles) begin
        @(negedge clk_in);
        seen = (intr_out === 1'b1);
        n++;
    end
    if (!seen) begin
        errors++;
        $display("intr_out did not rise within %0d cycles at %0t ns", max_cycles, $time);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Processor model
//////////////////////////////////////////////////////////////////////
task automatic proc_service(input int drop, input int bad_done);
    logic [7:0] cap;
    logic [4:0] done_c;
    logic [4:0] wrong_c;
    bit         seen;
    done_c  = (cur_mode == MODE_POLL) ? `IRQ_POLL_DONE : `IRQ_PRIO_DONE;
    wrong_c = (cur_mode == MODE_POLL) ? `IRQ_PRIO_DONE : `IRQ_POLL_DONE;
    wait_intr_out(200, seen);
    if (!seen) begin
        exp_q.delete();                             // Nothing will be captured
        return;
    end
    pulse_ack();                                    // First ack returns the id
    cap = intr_bus;
    check("intr_out", intr_out, 1'b0);
    cap_q.push_back(cap);
    -> bus_captured;
    if (drop == DROP_SERVED) begin
        intr_rq[cap[2:0]] = 1'b0;
    end else if (drop == DROP_ALL) begin
        intr_rq = '0;
    end
    pulse_ack();                                    // Id received
    for (int b = 0; b < bad_done; b++) begin
        // Wrong code on the first try and wrong id on the second
        intr_ack_bus = (b == 0) ? {wrong_c, cap[2:0]} : {done_c, cap[2:0] + 3'd1};
        pulse_ack();
        intr_ack_bus = '0;
        quiet_cycles(20);
    end
    intr_ack_bus = {done_c, cap[2:0]};
    pulse_ack();
    intr_ack_bus = '0;
endtask

`endif

/* bench/irq_ctrl_tb.sv */
`include "irq_defines.svh"

module irq_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import irq_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int DROP_NONE       = 0;     // Requests stay after service
    localparam int DROP_SERVED     = 1;     // Served source lets go
    localparam int DROP_ALL        = 2;     // Every request cleared

    // DUT ports
    logic        clk_in;
    logic        rst_in;
    logic [7:0]  intr_rq;
    logic [1:0]  intr_mode;
    logic [23:0] priorities_table;
    logic        intr_in;
    logic [7:0]  intr_ack_bus;
    logic        intr_out;
    logic [7:0]  intr_bus;

    // Bench state
    irq_mode_t   cur_mode;
    logic [31:0] rng_state;
    int          errors;
    int          checks_run;
    logic [2:0]  last_id;                   // Scan position the reference resumes from
    logic [7:0]  cap_q [$];                 // Captured bus words
    logic [7:0]  exp_q [$];                 // Reference grant words
    event        bus_captured;

    irq_ctrl dut (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_rq          (intr_rq),
        .intr_mode        (intr_mode),
        .priorities_table (priorities_table),
        .intr_in          (intr_in),
        .intr_ack_bus     (intr_ack_bus),
        .intr_out         (intr_out),
        .intr_bus         (intr_bus)
    );

    `include "irq_ctrl_tb_tasks.svh"

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;       // 100 ns period
    end

    // Run length bound
    initial begin : watchdog
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_in);
        $display("Run did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("Test failed");
        $finish;
    end

    // Compare each captured bus word with the reference
    initial begin : compare_proc
        logic [7:0] got;
        forever begin
            @(bus_captured);
            got = cap_q.pop_front();
            if (exp_q.size() == 0) begin
                errors++;
                $display("Bus word 0x%0h arrived with no expected grant", got);
            end else begin
                check("intr_bus", got, exp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : main
        logic [31:0] r;
        logic [23:0] tbl;
        logic [7:0]  exp_word;
        int          guard;
        rng_state        = 32'hc453_74c8;
        errors           = 0;
        checks_run       = 0;
        cur_mode         = MODE_NONE;
        priorities_table = '0;
        apply_reset();

        // Test 1 with no command or an invalid one
        check("intr_out", intr_out, 1'b0);
        check("intr_bus", intr_bus, 8'h00);
        intr_rq = rand_request();
        quiet_cycles(25);
        intr_mode = MODE_BAD;               // Invalid command ignored too
        quiet_cycles(25);
        report_test(1, "reset and invalid mode");

        // Test 2 with a single source in polling mode
        apply_reset();
        set_mode(MODE_POLL);
        for (int n = 0; n < 4; n++) begin
            r = next_rand();
            intr_rq = 8'h01 << r[2:0];
            exp_q.push_back(expected_grant(MODE_POLL, intr_rq, '0, 0));
            proc_service(DROP_ALL, 0);
        end
        report_test(2, "polling grant");

        // Test 3 serves a static set in cyclic order from 0
        apply_reset();
        set_mode(MODE_POLL);
        intr_rq = rand_request();
        guard = 0;
        while (intr_rq != 8'h00 && guard < 8) begin
            exp_word = expected_grant(MODE_POLL, intr_rq, '0, last_id);
            exp_q.push_back(exp_word);
            last_id = exp_word[2:0];
            proc_service(DROP_SERVED, 0);
            guard++;
        end
        report_test(3, "polling order");

        // Test 4 uses a permutation table and 20 request vectors
        apply_reset();
        build_table(tbl);
        priorities_table = tbl;
        set_mode(MODE_PRIO);
        for (int n = 0; n < 20; n++) begin
            intr_rq = rand_request();
            exp_q.push_back(expected_grant(MODE_PRIO, intr_rq, tbl, 0));
            proc_service(DROP_ALL, 0);
        end
        report_test(4, "priority grant");

        // Test 5 sends bad done words before the good one
        apply_reset();
        set_mode(MODE_POLL);
        intr_rq = rand_request();
        exp_word = expected_grant(MODE_POLL, intr_rq, '0, 0);
        exp_q.push_back(exp_word);
        last_id = exp_word[2:0];
        proc_service(DROP_NONE, 2);
        exp_q.push_back(expected_grant(MODE_POLL, intr_rq, '0, last_id));
        proc_service(DROP_ALL, 0);          // Next grant after the good done
        report_test(5, "wrong done ignored");

        $display("%0d checks, %0d errors", checks_run, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* design/irq_ctrl.sv */
`include "irq_defines.svh"

module irq_ctrl (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic [`IRQ_SRC_N-1:0]   intr_rq,            // Interrupt requests
    input  logic [1:0]              intr_mode,          // 01 polling, 10 priority
    input  logic [`IRQ_TABLE_W-1:0] priorities_table,   // Rank 0 in bits 2:0
    input  logic                    intr_in,            // Processor ack, active low
    input  logic [`IRQ_BUS_W-1:0]   intr_ack_bus,       // Done message
    output logic                    intr_out,           // Interrupt to processor
    output logic [`IRQ_BUS_W-1:0]   intr_bus            // Grant code and id
);

    import irq_pkg::*;

    logic                           load;
    logic [`IRQ_TABLE_W-1:0]        load_table;
    logic                           cfg_ready;
    logic                           poll_mode;
    logic [`IRQ_SRC_N-1:0]          hit;
    irq_id_t [`IRQ_SRC_N-1:0]       slot_id;
    logic                           win_valid;
    irq_id_t                        win_id;
    logic                           scan_en;

    //////////////////////////////////////////////////////////////////////
    // Configuration
    //////////////////////////////////////////////////////////////////////
    irq_mode_loader u_loader (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_mode        (irq_mode_t'(intr_mode)),
        .priorities_table (priorities_table),
        .load             (load),
        .load_table       (load_table),
        .cfg_ready        (cfg_ready),
        .poll_mode        (poll_mode)
    );

    // One slot per rank, each takes its 3-bit table field
    for (genvar k = 0; k < `IRQ_SRC_N; k++) begin : g_slot
        irq_priority_slot u_slot (
            .clk_in  (clk_in),
            .rst_in  (rst_in),
            .load    (load),
            .load_id (load_table[`IRQ_ID_W*k +: `IRQ_ID_W]),
            .intr_rq (intr_rq),
            .hit     (hit[k]),
            .slot_id (slot_id[k])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Arbitration and handshake
    //////////////////////////////////////////////////////////////////////
    irq_arbiter u_arbiter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .poll_mode (poll_mode),
        .cfg_ready (cfg_ready),
        .scan_en   (scan_en),
        .intr_rq   (intr_rq),
        .hit       (hit),
        .slot_id   (slot_id),
        .win_valid (win_valid),
        .win_id    (win_id)
    );

    irq_sequencer u_sequencer (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .cfg_ready    (cfg_ready),
        .poll_mode    (poll_mode),
        .win_valid    (win_valid),
        .win_id       (win_id),
        .intr_in      (intr_in),
        .intr_ack_bus (intr_ack_bus),
        .scan_en      (scan_en),
        .intr_out     (intr_out),
        .intr_bus     (intr_bus)
    );

endmodule

/* design/irq_sequencer.sv */
`include "irq_defines.svh"

module irq_sequencer (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  cfg_ready,        // Mode captured
    input  logic                  poll_mode,        // Selects the code pair
    input  logic                  win_valid,        // Arbiter has a winner
    input  irq_pkg::irq_id_t      win_id,           // Winner id
    input  logic                  intr_in,          // Processor ack, active low
    input  logic [`IRQ_BUS_W-1:0] intr_ack_bus,     // Done message
    output logic                  scan_en,          // Arbiter may advance
    output logic                  intr_out,         // Interrupt to processor
    output logic [`IRQ_BUS_W-1:0] intr_bus          // Grant code and id
);

    import irq_pkg::*;

    irq_seq_state_t        state_reg, state_next;
    logic                  intr_out_next;
    logic [`IRQ_BUS_W-1:0] intr_bus_next;
    irq_id_t               grant_id_reg;            // Source being serviced
    logic                  grant_id_ld;             // Capture winner
    logic [`IRQ_CODE_W-1:0] grant_code;
    logic [`IRQ_CODE_W-1:0] done_code;
    logic                  done_ok;                 // Done message matches

    // Code pair depends on the mode
    assign grant_code = poll_mode ? `IRQ_POLL_GRANT : `IRQ_PRIO_GRANT;
    assign done_code  = poll_mode ? `IRQ_POLL_DONE  : `IRQ_PRIO_DONE;

    // Done needs both the code and the serviced id
    assign done_ok = (intr_ack_bus == {done_code, grant_id_reg});

    assign scan_en = (state_reg == S_ARB);          // Index frozen during service

    //////////////////////////////////////////////////////////////////////
    // Next state and outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next    = state_reg;
        intr_out_next = intr_out;
        intr_bus_next = intr_bus;                   // Bus holds until the next grant
        grant_id_ld   = 1'b0;

        case (state_reg)
            S_IDLE: begin
                if (cfg_ready) begin
                    state_next = S_ARB;
                end
            end

            S_ARB: begin
                if (win_valid) begin
                    grant_id_ld   = 1'b1;
                    intr_out_next = 1'b1;           // Raise interrupt
                    state_next    = S_GRANT;
                end
            end

            // First ack drops intr_out and sends the id
            S_GRANT: begin
                if (!intr_in) begin
                    intr_out_next = 1'b0;
                    intr_bus_next = {grant_code, grant_id_reg};
                    state_next    = S_ID_ACK;
                end
            end

            S_ID_ACK: begin
                if (!intr_in) begin                 // Id received by processor
                    state_next = S_DONE;
                end
            end

            // Wrong messages are ignored, we keep waiting
            S_DONE: begin
                if (!intr_in && done_ok) begin
                    state_next = S_ARB;
                end
            end

            default: begin
                state_next    = S_IDLE;
                intr_out_next = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_reg <= S_IDLE;
            intr_out  <= 1'b0;
            intr_bus  <= '0;
        end else begin
            state_reg <= state_next;
            intr_out  <= intr_out_next;
            intr_bus  <= intr_bus_next;
        end
    end

    // Granted id, loaded on the winning edge
    always_ff @(posedge clk_in) begin
        if (grant_id_ld) begin
            grant_id_reg <= win_id;
        end
    end

endmodule

/* design/irq_arbiter.sv */
`include "irq_defines.svh"

module irq_arbiter (
    input  logic                                     clk_in,
    input  logic                                     rst_in,
    input  logic                                     poll_mode,  // Result select
    input  logic                                     cfg_ready,  // Loader finished
    input  logic                                     scan_en,    // Sequencer in S_ARB
    input  logic [`IRQ_SRC_N-1:0]                    intr_rq,    // Raw requests
    input  logic [`IRQ_SRC_N-1:0]                    hit,        // Per rank request
    input  irq_pkg::irq_id_t [`IRQ_SRC_N-1:0]        slot_id,    // Per rank source
    output logic                                     win_valid,  // A source wins this cycle
    output irq_pkg::irq_id_t                         win_id      // Winning source
);

    import irq_pkg::*;

    irq_id_t scan_idx_reg;              // Polling position
    logic    poll_hit;                  // Source under the index requests
    logic    prio_valid;                // Some rank requests
    irq_id_t prio_id;                   // Source of the best rank

    //////////////////////////////////////////////////////////////////////
    // Polling scan, one source per cycle
    //////////////////////////////////////////////////////////////////////
    assign poll_hit = intr_rq[scan_idx_reg];

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            scan_idx_reg <= '0;
        end else if (!cfg_ready) begin
            scan_idx_reg <= '0;                             // Start from source 0
        end else if (scan_en && poll_mode && !poll_hit) begin
            scan_idx_reg <= scan_idx_reg + 1'b1;            // Wraps after the last source
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Priority chain, rank 0 is best
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        prio_valid = 1'b0;
        prio_id    = '0;
        // Walk from the worst rank so the best hit is kept last
        for (int k = `IRQ_SRC_N - 1; k >= 0; k--) begin
            if (hit[k]) begin
                prio_valid = 1'b1;
                prio_id    = slot_id[k];
            end
        end
    end

    // Mode select, only meaningful while the sequencer arbitrates
    assign win_valid = scan_en && (poll_mode ? poll_hit : prio_valid);
    assign win_id    = poll_mode ? scan_idx_reg : prio_id;

endmodule

/* design/irq_priority_slot.sv */
`include "irq_defines.svh"

module irq_priority_slot (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  load,         // Table strobe from the loader
    input  irq_pkg::irq_id_t      load_id,      // This rank's entry
    input  logic [`IRQ_SRC_N-1:0] intr_rq,      // All request lines
    output logic                  hit,          // Ranked source requests
    output irq_pkg::irq_id_t      slot_id       // Ranked source id
);

    import irq_pkg::*;

    irq_id_t id_reg;                            // Source held by this rank

    // Id storage, source 0 until a table is loaded
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            id_reg <= '0;
        end else if (load) begin
            id_reg <= load_id;
        end
    end

    // Pick the request line of the stored source
    assign hit     = intr_rq[id_reg];
    assign slot_id = id_reg;

endmodule

/* design/irq_mode_loader.sv */
`include "irq_defines.svh"

module irq_mode_loader (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  irq_pkg::irq_mode_t      intr_mode,          // Command from the processor side
    input  logic [`IRQ_TABLE_W-1:0] priorities_table,   // Entry 0 in the low bits
    output logic                    load,               // One cycle strobe to the slots
    output logic [`IRQ_TABLE_W-1:0] load_table,         // Captured table
    output logic                    cfg_ready,          // Mode is known
    output logic                    poll_mode           // 1 polling, 0 priority
);

    import irq_pkg::*;

    // Capture steps
    typedef enum logic [1:0] {
        L_RESET,                        // One idle cycle after reset
        L_WAIT,                         // Sampling intr_mode
        L_READY                         // Configured until next reset
    } load_state_t;

    load_state_t state_reg;
    logic        cmd_valid;             // Command is polling or priority

    // Only the two defined commands are accepted
    assign cmd_valid = (intr_mode == MODE_POLL) || (intr_mode == MODE_PRIO);

    //////////////////////////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_reg <= L_RESET;
            load      <= 1'b0;
            cfg_ready <= 1'b0;
            poll_mode <= 1'b0;
        end else begin
            load <= 1'b0;                               // Strobe by default low
            case (state_reg)
                L_RESET: begin
                    state_reg <= L_WAIT;                // Start sampling next cycle
                end
                L_WAIT: begin
                    if (cmd_valid) begin
                        state_reg <= L_READY;
                        cfg_ready <= 1'b1;              // Stays set from here on
                        poll_mode <= (intr_mode == MODE_POLL);
                        load      <= (intr_mode == MODE_PRIO);  // Table only used in priority
                    end
                end
                L_READY: begin
                    state_reg <= L_READY;               // Mode is frozen
                end
                default: begin
                    state_reg <= L_RESET;
                end
            endcase
        end
    end

    // Table snapshot taken on the accepting edge
    always_ff @(posedge clk_in) begin
        if ((state_reg == L_WAIT) && cmd_valid) begin
            load_table <= priorities_table;
        end
    end

endmodule

/* design/irq_pkg.sv */
`include "irq_defines.svh"

package irq_pkg;

    // One interrupt source number
    typedef logic [`IRQ_ID_W-1:0] irq_id_t;

    // Command on intr_mode, only POLL and PRIO start the controller
    typedef enum logic [1:0] {
        MODE_NONE = 2'b00,              // No command yet
        MODE_POLL = 2'b01,              // Fixed order scan
        MODE_PRIO = 2'b10,              // Table driven priority
        MODE_BAD  = 2'b11               // Invalid, ignored
    } irq_mode_t;

    //////////////////////////////////////////////////////////////////////
    // Processor handshake sequencer
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,                // Waiting for configuration
        S_ARB    = 3'd1,                // Looking for a winner
        S_GRANT  = 3'd2,                // intr_out high, wait first ack
        S_ID_ACK = 3'd3,                // Id on bus, wait second ack
        S_DONE   = 3'd4                 // Wait for done message
    } irq_seq_state_t;

endpackage

/* design/irq_defines.svh */
`ifndef IRQ_DEFINES_SVH
`define IRQ_DEFINES_SVH

// Controller geometry
`define IRQ_SRC_N       8               // Interrupt sources
`define IRQ_ID_W        3               // Source id width
`define IRQ_BUS_W       8               // intr_bus / intr_ack_bus width
`define IRQ_CODE_W      5               // Code field above the id
`define IRQ_TABLE_W     24              // Eight packed 3-bit ids

//////////////////////////////////////////////////////////////////////
// Handshake codes, upper five bits of the bus word
//////////////////////////////////////////////////////////////////////

// Controller to processor, sent with the granted id
`define IRQ_POLL_GRANT  5'b01011        // Polling mode grant
`define IRQ_PRIO_GRANT  5'b10011        // Priority mode grant

// Processor to controller, service routine finished
`define IRQ_POLL_DONE   5'b10100        // Polling mode done
`define IRQ_PRIO_DONE   5'b01100        // Priority mode done

`endif
